/* sources.f */
+incdir+hw
+incdir+tests
hw/ram_pkg.sv
hw/ram_request_decode.sv
hw/ram_array_execute.sv
hw/ram_read_result.sv
hw/sp_ram_top.sv
tests/tb_sp_ram.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs tb_sp_ram with Verilator once for each read-during-write mode.
# Mode 0 is write-first, 1 is read-first, 2 is no-change.
# A mode fails when the build or run breaks, or when its log holds the fail message.

status=0

for mode in 0 1 2; do
    log="sim_mode${mode}.log"
    objdir="obj_dir_mode${mode}"
    echo "mode ${mode}: building and running"

    verilator --binary --timing --timescale 1ns/10ps \
        --top-module tb_sp_ram -Grdw_mode=${mode} \
        -f sources.f -Mdir "${objdir}" -o sim_tb > "${log}" 2>&1 &&
        "./${objdir}/sim_tb" >> "${log}" 2>&1 ||
        { echo "mode ${mode}: build or run error, see ${log}"; status=1; }

    grep -q "Simulation failed" "${log}" &&
        { echo "mode ${mode}: testbench reported a failure, see ${log}"; status=1; }
done

if [ ${status} -eq 0 ]; then
    echo "all read-during-write modes completed without failure"
else
    echo "at least one read-during-write mode failed"
fi

exit ${status}

/* tests/tb_ram_model.svh */
// reference model included inside tb_sp_ram; it expects mode_sel and test_reads to be declared before the include
`ifndef TB_RAM_MODEL_SVH
`define TB_RAM_MODEL_SVH

localparam int model_lane_width = `RAM_DATA_WIDTH / `RAM_LANES;

// every word is written by the first test before any read, so no entry stays undefined
ram_data_t model_mem [0:`RAM_DEPTH-1];
ram_data_t model_last_rsp;
ram_data_t expect_q [$];

// the response register of the RAM comes out of reset holding zero
function automatic void model_reset();
    model_last_rsp = '0;
    expect_q.delete();
endfunction

// called once for each request that transfers, in transfer order
function automatic void model_request(
    input logic      rd,
    input logic      wr,
    input ram_wren_t wren,
    input ram_addr_t addr,
    input ram_data_t wdata
);
    ram_data_t old_word;
    ram_data_t new_word;
    ram_data_t lane_mask;
    ram_data_t rsp;
    logic      writes;

    old_word  = model_mem[addr];
    lane_mask = '0;
    for (int i = 0; i < `RAM_LANES; i++) begin
        if (wren[i]) begin
            lane_mask[i*model_lane_width +: model_lane_width] = '1;
        end
    end
    new_word = (old_word & ~lane_mask) | (wdata & lane_mask);

    // with no lane enabled the request does not count as a write
    writes = wr && (wren != '0);

    if (rd) begin
        if (!writes) begin
            rsp = old_word;
        end else if (mode_sel == rdw_write_first) begin
            rsp = new_word;
        end else if (mode_sel == rdw_read_first) begin
            rsp = old_word;
        end else begin
            rsp = model_last_rsp;
        end
        expect_q.push_back(rsp);
        model_last_rsp = rsp;
        test_reads++;
    end

    if (writes) begin
        model_mem[addr] = new_word;
    end
endfunction

`endif

/* tests/tb_sp_ram.sv */
// testbench for sp_ram_top; the mode comes from the rdw_mode parameter and all stimulus from one seed
`timescale 1ns/10ps

`include "ram_settings.svh"

module tb_sp_ram #(
    parameter int rdw_mode = `RAM_RDW_MODE
);

    import ram_pkg::*;

    localparam int n_merge        = 150;
    localparam int n_rw           = 150;
    localparam int n_stall        = 250;
    localparam int n_mix          = 250;
    localparam int total_requests = 2*`RAM_DEPTH + 2*n_merge + 2*n_rw + n_stall + n_mix;
    localparam int cycle_limit    = 4*total_requests + 500;
    localparam rdw_mode_e mode_sel = rdw_mode_e'(rdw_mode);

    logic      clk;
    logic      reset;
    logic      req_valid;
    logic      req_read;
    logic      req_write;
    ram_wren_t req_wren;
    ram_addr_t req_addr;
    ram_data_t req_wdata;
    logic      rsp_ready;
    logic      req_ready;
    logic      rsp_valid;
    ram_data_t rsp_data;

    integer    seed;
    int        cycles;
    logic      stall_en;
    string     test_name;
    int        test_checks;
    int        test_errors;
    int        test_reads;
    int        test_rsps;
    int        total_checks;
    int        total_errors;
    int        tests_run;
    logic      held_valid;
    ram_data_t held_data;

    `include "tb_ram_model.svh"

    sp_ram_top #(
        .RDW_MODE (mode_sel)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_read  (req_read),
        .req_write (req_write),
        .req_wren  (req_wren),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_ready (rsp_ready),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles in test %s with %0d responses outstanding",
                 cycles, test_name, expect_q.size());
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] rand_bits();
        return $random(seed);
    endfunction

    function automatic ram_addr_t rand_addr();
        logic [31:0] r;
        r = rand_bits();
        return r[`RAM_ADDR_WIDTH-1:0];
    endfunction

    function automatic ram_wren_t rand_wren();
        logic [31:0] r;
        r = rand_bits();
        return r[`RAM_LANES-1:0];
    endfunction

    // outputs are sampled mid-cycle, where they hold the values the next rising edge uses
    initial begin
        ram_data_t expected;
        held_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (held_valid) begin
                if (!rsp_valid) begin
                    $display("test %s: response was withdrawn while rsp_ready was low", test_name);
                    test_errors++;
                end else if (rsp_data !== held_data) begin
                    $display("** Error test %s: expected %h actual %h while stalled",
                             test_name, held_data, rsp_data);
                    test_errors++;
                end
            end
            held_valid = rsp_valid && !rsp_ready;
            held_data  = rsp_data;
            if (rsp_valid && rsp_ready) begin
                test_rsps++;
                if (expect_q.size() == 0) begin
                    $display("test %s: response arrived with no read request behind it",
                             test_name);
                    test_errors++;
                end else begin
                    expected = expect_q.pop_front();
                    test_checks++;
                    if (rsp_data !== expected) begin
                        $display("** Error test %s: expected %h actual %h",
                                 test_name, expected, rsp_data);
                        test_errors++;
                    end
                end
            end
        end
    end

    // moves to 2 ns after the next rising edge and drives rsp_ready
    task automatic step();
        logic [31:0] r;
        @(posedge clk);
        #2;
        if (stall_en) begin
            r = rand_bits();
            rsp_ready = (r[1:0] != 2'b00);
        end else begin
            rsp_ready = 1'b1;
        end
    endtask

    task automatic send_request(
        input logic      rd,
        input logic      wr,
        input ram_wren_t wren,
        input ram_addr_t addr,
        input ram_data_t wdata
    );
        logic accepted;
        req_valid = 1'b1;
        req_read  = rd;
        req_write = wr;
        req_wren  = wren;
        req_addr  = addr;
        req_wdata = wdata;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            if (req_ready) begin
                accepted = 1'b1;
                model_request(rd, wr, wren, addr, wdata);
            end
            step();
        end
        req_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
        test_reads  = 0;
        test_rsps   = 0;
    endtask

    task automatic finish_test();
        while (expect_q.size() != 0) begin
            step();
        end
        step();
        step();
        if (test_rsps != test_reads) begin
            $display("test %s: %0d read requests but %0d responses",
                     test_name, test_reads, test_rsps);
            test_errors++;
        end
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_run++;
    endtask

    initial begin
        logic [31:0] r;
        ram_addr_t   a;
        seed         = 32'h937a;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_read     = 1'b0;
        req_write    = 1'b0;
        req_wren     = '0;
        req_addr     = '0;
        req_wdata    = '0;
        rsp_ready    = 1'b1;
        stall_en     = 1'b0;
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;
        test_name    = "reset";
        model_reset();
        $display("read-during-write mode %0d", rdw_mode);

        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        start_test("write_read_back");
        for (int i = 0; i < `RAM_DEPTH; i++) begin
            send_request(1'b0, 1'b1, '1, ram_addr_t'(i), rand_bits());
        end
        for (int i = 0; i < `RAM_DEPTH; i++) begin
            send_request(1'b1, 1'b0, '0, ram_addr_t'(i), '0);
        end
        finish_test();

        start_test("lane_merge");
        for (int i = 0; i < n_merge; i++) begin
            a = rand_addr();
            send_request(1'b0, 1'b1, rand_wren(), a, rand_bits());
            send_request(1'b1, 1'b0, '0, a, '0);
        end
        finish_test();

        // a zero lane enable here turns the read-write into a plain read
        start_test("read_during_write");
        for (int i = 0; i < n_rw; i++) begin
            a = rand_addr();
            send_request(1'b1, 1'b1, rand_wren(), a, rand_bits());
            send_request(1'b1, 1'b0, '0, rand_addr(), '0);
        end
        finish_test();

        start_test("back_pressure");
        stall_en = 1'b1;
        for (int i = 0; i < n_stall; i++) begin
            r = rand_bits();
            send_request(r[1:0] != 2'd1, (r[1:0] == 2'd1) || (r[1:0] == 2'd2),
                         rand_wren(), rand_addr(), rand_bits());
        end
        finish_test();
        stall_en = 1'b0;

        // idle requests, write-only requests and gaps with req_valid low
        start_test("no_response");
        for (int i = 0; i < n_mix; i++) begin
            r = rand_bits();
            send_request(r[1:0] == 2'd3, (r[1:0] == 2'd1) || (r[1:0] == 2'd2),
                         rand_wren(), rand_addr(), rand_bits());
            if (r[2]) begin
                step();
            end
        end
        finish_test();

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, total_checks,
                 total_errors);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* hw/sp_ram_top.sv */
// single-port RAM behind valid/ready streams; two-edge read latency, one request per cycle, stall halts all stages
`timescale 1ns/10ps

`include "ram_settings.svh"

module sp_ram_top #(
    parameter ram_pkg::rdw_mode_e RDW_MODE = ram_pkg::rdw_mode_e'(`RAM_RDW_MODE)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  logic               req_read,
    input  logic               req_write,
    input  ram_pkg::ram_wren_t req_wren,
    input  ram_pkg::ram_addr_t req_addr,
    input  ram_pkg::ram_data_t req_wdata,
    input  logic               rsp_ready,
    output logic               req_ready,
    output logic               rsp_valid,
    output ram_pkg::ram_data_t rsp_data
);

    import ram_pkg::*;

    logic      stall;
    logic      dec_valid;
    ram_op_e   dec_op;
    ram_addr_t dec_addr;
    ram_wren_t dec_wren;
    ram_data_t dec_wdata;
    ram_data_t old_data;
    ram_data_t new_data;

    // a held response freezes every stage, so nothing can be overwritten
    assign stall     = rsp_valid && !rsp_ready;
    assign req_ready = !stall;

    ram_request_decode decode (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_read  (req_read),
        .req_write (req_write),
        .req_wren  (req_wren),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .stall     (stall),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_addr  (dec_addr),
        .dec_wren  (dec_wren),
        .dec_wdata (dec_wdata)
    );

    ram_array_execute execute (
        .clk       (clk),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_addr  (dec_addr),
        .dec_wren  (dec_wren),
        .dec_wdata (dec_wdata),
        .stall     (stall),
        .old_data  (old_data),
        .new_data  (new_data)
    );

    ram_read_result #(
        .rdw_mode (RDW_MODE)
    ) result (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .old_data  (old_data),
        .new_data  (new_data),
        .stall     (stall),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

endmodule

/* hw/ram_read_result.sv */
// read result register; in no-change mode a read-write issued before any read returns zero
`timescale 1ns/10ps

module ram_read_result #(
    parameter ram_pkg::rdw_mode_e rdw_mode = ram_pkg::rdw_write_first
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               dec_valid,
    input  ram_pkg::ram_op_e   dec_op,
    input  ram_pkg::ram_data_t old_data,
    input  ram_pkg::ram_data_t new_data,
    input  logic               stall,
    output logic               rsp_valid,
    output ram_pkg::ram_data_t rsp_data
);

    import ram_pkg::*;

    logic      is_read;
    logic      load;
    ram_data_t sel_data;

    assign is_read = dec_valid && ((dec_op == op_read) || (dec_op == op_read_write));
    assign load    = is_read && !stall;

    // a plain read always sees the stored word, only read-write depends on the mode
    always_comb begin
        sel_data = old_data;
        if (dec_op == op_read_write) begin
            case (rdw_mode)
                rdw_write_first: begin
                    sel_data = new_data;
                end
                rdw_read_first: begin
                    sel_data = old_data;
                end
                default: begin
                    // no-change repeats whatever was last returned
                    sel_data = rsp_data;
                end
            endcase
        end
    end

    // without stall the register is either empty or draining this cycle,
    // so it simply takes the next read or goes empty
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (!stall) begin
            rsp_valid <= is_read;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_data <= '0;
        end else if (load) begin
            rsp_data <= sel_data;
        end
    end

endmodule

/* hw/ram_array_execute.sv */
// storage array with byte-lane merge; contents are undefined until written and there is no reset of the array
`timescale 1ns/10ps

`include "ram_settings.svh"

module ram_array_execute (
    input  logic               clk,
    input  logic               dec_valid,
    input  ram_pkg::ram_op_e   dec_op,
    input  ram_pkg::ram_addr_t dec_addr,
    input  ram_pkg::ram_wren_t dec_wren,
    input  ram_pkg::ram_data_t dec_wdata,
    input  logic               stall,
    output ram_pkg::ram_data_t old_data,
    output ram_pkg::ram_data_t new_data
);

    import ram_pkg::*;

    localparam int lane_width = `RAM_DATA_WIDTH / `RAM_LANES;

    ram_data_t mem [0:`RAM_DEPTH-1];
    logic      op_writes;
    logic      do_write;

    // word currently addressed by the decode stage
    assign old_data = mem[dec_addr];

    // enabled lanes take the write data, the rest keep the stored bytes
    always_comb begin
        new_data = old_data;
        for (int i = 0; i < `RAM_LANES; i++) begin
            if (dec_wren[i]) begin
                new_data[i*lane_width +: lane_width] = dec_wdata[i*lane_width +: lane_width];
            end
        end
    end

    assign op_writes = (dec_op == op_write) || (dec_op == op_read_write);

    // the write lands on the same edge that moves the item out of decode
    assign do_write = dec_valid && op_writes && !stall;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[dec_addr] <= new_data;
        end
    end

endmodule

/* hw/ram_request_decode.sv */
// request decode stage; a write with no lane enabled is treated as no write, and the stage holds while stalled
`timescale 1ns/10ps

module ram_request_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  logic               req_read,
    input  logic               req_write,
    input  ram_pkg::ram_wren_t req_wren,
    input  ram_pkg::ram_addr_t req_addr,
    input  ram_pkg::ram_data_t req_wdata,
    input  logic               stall,
    output logic               dec_valid,
    output ram_pkg::ram_op_e   dec_op,
    output ram_pkg::ram_addr_t dec_addr,
    output ram_pkg::ram_wren_t dec_wren,
    output ram_pkg::ram_data_t dec_wdata
);

    import ram_pkg::*;

    logic    has_write;
    logic    req_accept;
    ram_op_e req_op;

    // a write only counts when at least one lane is enabled
    assign has_write = req_write && (|req_wren);

    // the top level ties req_ready to the inverse of stall
    assign req_accept = req_valid && !stall;

    always_comb begin
        case ({has_write, req_read})
            2'b11: begin
                req_op = op_read_write;
            end
            2'b10: begin
                req_op = op_write;
            end
            2'b01: begin
                req_op = op_read;
            end
            default: begin
                req_op = op_none;
            end
        endcase
    end

    // control part of the decode register
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_op    <= op_none;
        end else if (!stall) begin
            dec_valid <= req_accept;
            if (req_accept) begin
                dec_op <= req_op;
            end else begin
                dec_op <= op_none;
            end
        end
    end

    // payload only moves when a request is taken
    always_ff @(posedge clk) begin
        if (req_accept) begin
            dec_addr  <= req_addr;
            dec_wren  <= req_wren;
            dec_wdata <= req_wdata;
        end
    end

endmodule

/* hw/ram_pkg.sv */
// shared RAM types; widths come from ram_settings.svh and the enum encodings are fixed at two bits
package ram_pkg;

    `include "ram_settings.svh"

    // one stored word
    typedef logic [`RAM_DATA_WIDTH-1:0] ram_data_t;

    // word address into the array
    typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;

    // one write enable per byte lane
    typedef logic [`RAM_LANES-1:0] ram_wren_t;

    // bit 0 marks a read and bit 1 marks a write
    typedef enum logic [1:0] {
        op_none       = 2'b00,
        op_read       = 2'b01,
        op_write      = 2'b10,
        op_read_write = 2'b11
    } ram_op_e;

    // what a read returns when the same request also writes the word
    typedef enum logic [1:0] {
        rdw_write_first = 2'd0,
        rdw_read_first  = 2'd1,
        rdw_no_change   = 2'd2
    } rdw_mode_e;

endpackage

/* hw/ram_settings.svh */
// sizing for the single-port RAM; data width must divide evenly by the lane count and depth must equal 2**addr width
`ifndef RAM_SETTINGS_SVH
`define RAM_SETTINGS_SVH

// one word of storage and the byte lanes that split it
`define RAM_DATA_WIDTH 32
`define RAM_LANES      4

// depth and the matching word address width
`define RAM_DEPTH      64
`define RAM_ADDR_WIDTH 6

// default read-during-write mode, using the rdw_mode_e encoding
// 0 is write-first, 1 is read-first, 2 is no-change
`define RAM_RDW_MODE   0

`endif
